/* include/cim_consts.svh */
`ifndef CIM_CONSTS_SVH
`define CIM_CONSTS_SVH

// Epoch geometry
`define PATCH_LEN 8
`define NUM_PATCHES 4

// Embedding rows, one projection lane each
`define EMB_DEPTH 4

// Data widths
`define ADC_BITS 8
`define PARAM_BITS 8
`define ACC_BITS 20 // Holds PATCH_LEN products plus bias without overflow

`endif

/* hw/cim_pkg.sv */
`include "cim_consts.svh"

package cim_pkg;

    // Basic data and index types
    typedef logic [`ADC_BITS-1:0] sample_t;
    typedef logic signed [`PARAM_BITS-1:0] param_t;
    typedef logic signed [`ACC_BITS-1:0] acc_t;
    typedef logic [$clog2(`PATCH_LEN)-1:0] col_idx_t;
    typedef logic [$clog2(`EMB_DEPTH)-1:0] row_idx_t;
    typedef logic [$clog2(`NUM_PATCHES)-1:0] patch_idx_t;

    typedef enum logic [1:0] {
        IDLE,
        EEG_LOAD,
        INFERENCE
    } cim_state_e;

    typedef enum logic {
        WEIGHT,
        BIAS
    } param_kind_e;

    typedef struct packed {
        logic valid;
        param_kind_e kind;
        row_idx_t row;
        col_idx_t col; // Ignored for bias writes
        param_t data;
    } param_wr_t;

    typedef struct packed {
        logic valid;
        logic first;
        logic last;
        col_idx_t col;
        sample_t sample;
    } lane_feed_t;

    typedef struct packed {
        logic valid;
        patch_idx_t patch;
        row_idx_t row;
        acc_t result;
    } emb_out_t;

endpackage

/* hw/patch_sequencer.sv */
`timescale 1ns/1ps
`include "cim_consts.svh"

module patch_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   eeg_valid_i,
    input  logic [`ADC_BITS-1:0]   eeg_i,
    input  logic                   start_i,
    output cim_pkg::lane_feed_t    feed_o,
    output logic                   busy_o
);
    import cim_pkg::*;

    localparam int EPOCH_LEN = `NUM_PATCHES * `PATCH_LEN;
    localparam int POS_BITS = $clog2(EPOCH_LEN);

    cim_state_e state_q;
    logic [POS_BITS-1:0] load_pos_q;
    patch_idx_t patch_q;
    col_idx_t col_q;
    logic [POS_BITS-1:0] rd_addr;
    logic load_en;

    sample_t eeg_buf_q [EPOCH_LEN];

    // Loading is allowed whenever no inference is running
    assign load_en = eeg_valid_i && (state_q != INFERENCE);

    always_ff @(posedge clk) begin
        if (load_en) begin
            eeg_buf_q[load_pos_q] <= eeg_i; // Patch-major order
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
            load_pos_q <= '0;
            patch_q <= '0;
            col_q <= '0;
        end else begin
            unique case (state_q)
                IDLE, EEG_LOAD: begin
                    if (load_en) begin
                        state_q <= EEG_LOAD;
                        if (int'(load_pos_q) == EPOCH_LEN - 1) begin
                            load_pos_q <= '0;
                        end else begin
                            load_pos_q <= load_pos_q + 1'b1;
                        end
                    end
                    if (start_i) begin
                        state_q <= INFERENCE;
                        load_pos_q <= '0; // Next load starts a fresh epoch
                        patch_q <= '0;
                        col_q <= '0;
                    end
                end
                INFERENCE: begin
                    // One sample per cycle, patches back to back
                    if (int'(col_q) == `PATCH_LEN - 1) begin
                        col_q <= '0;
                        if (int'(patch_q) == `NUM_PATCHES - 1) begin
                            patch_q <= '0;
                            state_q <= IDLE;
                        end else begin
                            patch_q <= patch_q + 1'b1;
                        end
                    end else begin
                        col_q <= col_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    assign rd_addr = POS_BITS'(int'(patch_q) * `PATCH_LEN + int'(col_q));

    always_comb begin
        feed_o.valid = (state_q == INFERENCE);
        feed_o.first = (col_q == '0);
        feed_o.last = (int'(col_q) == `PATCH_LEN - 1);
        feed_o.col = col_q;
        feed_o.sample = eeg_buf_q[rd_addr];
    end

    assign busy_o = (state_q == INFERENCE);

endmodule

/* hw/proj_lane.sv */
`timescale 1ns/1ps
`include "cim_consts.svh"

module proj_lane #(
    parameter int ROW = 0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  cim_pkg::param_wr_t          param_wr_i,
    input  cim_pkg::lane_feed_t         feed_i,
    output logic                        result_valid_o,
    output logic signed [`ACC_BITS-1:0] result_o
);
    import cim_pkg::*;

    param_t weight_q [`PATCH_LEN];
    param_t bias_q;
    acc_t acc_q;
    acc_t product;
    acc_t acc_sum;
    logic row_hit;

    assign row_hit = param_wr_i.valid && (param_wr_i.row == row_idx_t'(ROW));

    // Parameters written by the host
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `PATCH_LEN; i++) begin
                weight_q[i] <= '0;
            end
            bias_q <= '0;
        end else if (row_hit) begin
            unique case (param_wr_i.kind)
                WEIGHT: weight_q[param_wr_i.col] <= param_wr_i.data;
                BIAS: bias_q <= param_wr_i.data;
                default: ;
            endcase
        end
    end

    always_comb begin
        // Sample is unsigned, weight signed
        product = $signed({1'b0, feed_i.sample}) * weight_q[feed_i.col];
        acc_sum = (feed_i.first ? acc_t'(0) : acc_q) + product;
    end

    always_ff @(posedge clk) begin
        if (feed_i.valid) begin
            acc_q <= acc_sum;
        end
        if (feed_i.valid && feed_i.last) begin
            result_o <= acc_sum + acc_t'(bias_q); // Bias sign-extended
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= feed_i.valid && feed_i.last;
        end
    end

endmodule

/* hw/emb_collector.sv */
`timescale 1ns/1ps
`include "cim_consts.svh"

module emb_collector (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                lane_valid_i,
    input  cim_pkg::acc_t [`EMB_DEPTH-1:0]      lane_result_i,
    output cim_pkg::emb_out_t                   emb_o,
    output logic                                done_o,
    output logic                                draining_o
);
    import cim_pkg::*;

    acc_t [`EMB_DEPTH-1:0] res_q;
    row_idx_t row_q;
    patch_idx_t patch_q;
    logic pending_q;

    // All lanes finish together, so one capture takes every row
    always_ff @(posedge clk) begin
        if (lane_valid_i) begin
            res_q <= lane_result_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending_q <= 1'b0;
            row_q <= '0;
            patch_q <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (lane_valid_i) begin
                pending_q <= 1'b1;
                row_q <= '0;
            end else if (pending_q) begin
                if (int'(row_q) == `EMB_DEPTH - 1) begin
                    pending_q <= 1'b0;
                    row_q <= '0;
                    if (int'(patch_q) == `NUM_PATCHES - 1) begin
                        patch_q <= '0;
                        done_o <= 1'b1; // Whole epoch emitted
                    end else begin
                        patch_q <= patch_q + 1'b1;
                    end
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end
        end
    end

    // One row per cycle
    always_comb begin
        emb_o.valid = pending_q;
        emb_o.patch = patch_q;
        emb_o.row = row_q;
        emb_o.result = res_q[row_q];
    end

    // Also covers the cycle where the final lane strobe arrives
    assign draining_o = pending_q || lane_valid_i || (patch_q != '0);

endmodule

/* hw/cim_top.sv */
`timescale 1ns/1ps
`include "cim_consts.svh"

module cim_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   eeg_valid_i,
    input  logic [`ADC_BITS-1:0]   eeg_i,
    input  logic                   start_i,
    input  cim_pkg::param_wr_t     param_wr_i,
    output cim_pkg::emb_out_t      emb_o,
    output logic                   done_o,
    output logic                   busy_o
);
    import cim_pkg::*;

    lane_feed_t feed;
    logic seq_busy;
    logic draining;
    logic [`EMB_DEPTH-1:0] lane_valid;
    acc_t [`EMB_DEPTH-1:0] lane_result;

    patch_sequencer seq_u (
        .clk         (clk),
        .rst_n       (rst_n),
        .eeg_valid_i (eeg_valid_i),
        .eeg_i       (eeg_i),
        .start_i     (start_i),
        .feed_o      (feed),
        .busy_o      (seq_busy)
    );

    // One lane per embedding row, all fed the same sample
    for (genvar g = 0; g < `EMB_DEPTH; g++) begin : gen_lane
        proj_lane #(.ROW(g)) lane_u (
            .clk            (clk),
            .rst_n          (rst_n),
            .param_wr_i     (param_wr_i),
            .feed_i         (feed),
            .result_valid_o (lane_valid[g]),
            .result_o       (lane_result[g])
        );
    end

    emb_collector coll_u (
        .clk           (clk),
        .rst_n         (rst_n),
        .lane_valid_i  (lane_valid[0]), // Lanes run in lockstep
        .lane_result_i (lane_result),
        .emb_o         (emb_o),
        .done_o        (done_o),
        .draining_o    (draining)
    );

    assign busy_o = seq_busy || draining;

endmodule

/* bench/cim_checker.sv */
`timescale 1ns/1ps
`include "cim_consts.svh"

module cim_checker (
    input logic              clk,
    input logic              rst_n,
    input logic              start_i,
    input cim_pkg::emb_out_t emb_o,
    input logic              done_o,
    input logic              busy_o
);
    import cim_pkg::*;

    localparam patch_idx_t LAST_PATCH = patch_idx_t'(`NUM_PATCHES - 1);
    localparam row_idx_t LAST_ROW = row_idx_t'(`EMB_DEPTH - 1);

    int fail_count = 0;
    logic accepted_start;
    logic last_result;

    assign accepted_start = start_i && !busy_o; // Starts during inference do nothing
    assign last_result = emb_o.valid && (emb_o.patch == LAST_PATCH) && (emb_o.row == LAST_ROW);

    quiet_after_reset: assert property (@(posedge clk)
        !rst_n |=> !emb_o.valid && !done_o && !busy_o)
    else begin
        fail_count++;
        $error("emb_o, done_o or busy_o active right after reset");
    end

    // Idle stays idle without a start
    idle_stays_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !busy_o && !start_i |=> !busy_o && !emb_o.valid && !done_o)
    else begin
        fail_count++;
        $error("activity without an accepted start_i");
    end

    first_result_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(accepted_start, `PATCH_LEN + 2) |-> emb_o.valid && emb_o.patch == '0
                                                   && emb_o.row == '0)
    else begin
        fail_count++;
        $error("first emb_o strobe missing PATCH_LEN+2 cycles after start_i");
    end

    no_early_result: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(emb_o.valid) && emb_o.patch == '0 |-> $past(accepted_start, `PATCH_LEN + 2))
    else begin
        fail_count++;
        $error("first emb_o strobe at the wrong distance from start_i");
    end

    done_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        last_result |=> done_o)
    else begin
        fail_count++;
        $error("done_o missing one cycle after the last result");
    end

    done_needs_last: assert property (@(posedge clk) disable iff (!rst_n)
        done_o |-> $past(last_result))
    else begin
        fail_count++;
        $error("done_o without a preceding last result");
    end

    done_one_wide: assert property (@(posedge clk) disable iff (!rst_n) done_o |=> !done_o)
    else begin
        fail_count++;
        $error("done_o wider than one cycle");
    end

    busy_after_start: assert property (@(posedge clk) disable iff (!rst_n)
        accepted_start |=> busy_o)
    else begin
        fail_count++;
        $error("busy_o low in the cycle after start_i");
    end

    // Busy holds until done
    busy_until_done: assert property (@(posedge clk) disable iff (!rst_n)
        busy_o && !done_o |=> busy_o || done_o)
    else begin
        fail_count++;
        $error("busy_o dropped before done_o");
    end

    // Successive patches start PATCH_LEN cycles apart
    patch_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(emb_o.valid) && emb_o.patch != LAST_PATCH
            |-> ##(`PATCH_LEN) $rose(emb_o.valid))
    else begin
        fail_count++;
        $error("next patch did not start PATCH_LEN cycles after the previous one");
    end

endmodule

bind cim_top cim_checker checker_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start_i (start_i),
    .emb_o   (emb_o),
    .done_o  (done_o),
    .busy_o  (busy_o)
);

/* bench/cim_tb.sv */
`timescale 1ns/1ps
`include "cim_consts.svh"

module cim_tb;
    import cim_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int NUM_RESULTS = `NUM_PATCHES * `EMB_DEPTH;
    localparam int PARAM_CYCLES = `EMB_DEPTH * (`PATCH_LEN + 1);
    localparam int LOAD_CYCLES = `NUM_PATCHES * `PATCH_LEN;
    localparam int RUN_LIMIT = `NUM_PATCHES * `PATCH_LEN + `EMB_DEPTH + 8;
    localparam int TOTAL_CYCLES = 14 + PARAM_CYCLES + 2 * LOAD_CYCLES + `EMB_DEPTH
                                  + 5 * (RUN_LIMIT + 4);
    localparam int WATCHDOG_NS = (TOTAL_CYCLES + 100) * CLK_PERIOD;

    logic clk;
    logic rst_n;
    logic eeg_valid_i;
    logic [`ADC_BITS-1:0] eeg_i;
    logic start_i;
    param_wr_t param_wr_i;
    emb_out_t emb_o;
    logic done_o;
    logic busy_o;

    // Reference copies of everything written to the DUT
    sample_t samples [`NUM_PATCHES][`PATCH_LEN];
    param_t weights [`EMB_DEPTH][`PATCH_LEN];
    param_t biases [`EMB_DEPTH];
    int observed [`NUM_PATCHES][`EMB_DEPTH];
    int errors;
    int tests_failed;
    int strobes;
    int first_strobe;
    int last_strobe;
    int done_at;

    cim_top cim_top_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .eeg_valid_i (eeg_valid_i),
        .eeg_i       (eeg_i),
        .start_i     (start_i),
        .param_wr_i  (param_wr_i),
        .emb_o       (emb_o),
        .done_o      (done_o),
        .busy_o      (busy_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired: the run went past %0d ns", WATCHDOG_NS);
        $display("Something failed");
        $finish;
    end

    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DELAY);
    endtask

    task automatic flag_mismatch(input string msg);
        $display("FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    function automatic int total_failures();
        return errors + cim_top_i.checker_i.fail_count;
    endfunction

    // Dot product of the patch with the row weights, plus the row bias
    function automatic int model_result(input int p, input int r);
        int acc;
        acc = int'(biases[r]);
        for (int c = 0; c < `PATCH_LEN; c++) begin
            acc += int'(samples[p][c]) * int'(weights[r][c]);
        end
        return acc;
    endfunction

    task automatic write_param(input param_kind_e kind, input int row, input int col,
                               input param_t data);
        param_wr_i.valid = 1'b1;
        param_wr_i.kind = kind;
        param_wr_i.row = row_idx_t'(row);
        param_wr_i.col = col_idx_t'(col);
        param_wr_i.data = data;
        next_cycle();
        param_wr_i = '0;
    endtask

    task automatic load_params();
        for (int r = 0; r < `EMB_DEPTH; r++) begin
            for (int c = 0; c < `PATCH_LEN; c++) begin
                write_param(WEIGHT, r, c, weights[r][c]);
            end
            write_param(BIAS, r, 0, biases[r]);
        end
    endtask

    task automatic load_epoch();
        for (int p = 0; p < `NUM_PATCHES; p++) begin
            for (int c = 0; c < `PATCH_LEN; c++) begin
                eeg_valid_i = 1'b1;
                eeg_i = samples[p][c];
                next_cycle();
            end
        end
        eeg_valid_i = 1'b0;
    endtask

    task automatic run_epoch(input bit extra_start);
        int cycles;
        bit done_seen;
        int exp_patch;
        int exp_row;
        int exp_val;
        start_i = 1'b1;
        next_cycle();
        start_i = 1'b0;
        strobes = 0;
        first_strobe = 0;
        last_strobe = 0;
        done_at = 0;
        cycles = 1; // Counts the sampling edges after the start edge
        done_seen = 1'b0;
        while (!done_seen && cycles < RUN_LIMIT) begin
            next_cycle();
            cycles++;
            assert (busy_o || done_o) else flag_mismatch("busy_o low before done_o");
            if (emb_o.valid && strobes >= NUM_RESULTS) begin
                flag_mismatch("emb_o strobe beyond the epoch");
            end else if (emb_o.valid) begin
                exp_patch = strobes / `EMB_DEPTH;
                exp_row = strobes % `EMB_DEPTH;
                exp_val = model_result(exp_patch, exp_row);
                assert (emb_o.patch == patch_idx_t'(exp_patch)
                        && emb_o.row == row_idx_t'(exp_row))
                else flag_mismatch($sformatf("strobe %0d is patch %0d row %0d",
                                             strobes, emb_o.patch, emb_o.row));
                assert (emb_o.result == acc_t'(exp_val))
                else flag_mismatch($sformatf("patch %0d row %0d gave %0d, expected %0d",
                                             exp_patch, exp_row, emb_o.result, exp_val));
                observed[exp_patch][exp_row] = int'(emb_o.result);
                if (strobes == 0) begin
                    first_strobe = cycles;
                end
                last_strobe = cycles;
                strobes++;
            end
            if (done_o) begin
                done_seen = 1'b1;
                done_at = cycles;
            end
            start_i = extra_start && (cycles == `PATCH_LEN + 4); // Mid-run start pulse
        end
        start_i = 1'b0;
        if (!done_seen) begin
            $display("Timeout: done_o did not arrive within %0d cycles of start_i", RUN_LIMIT);
            errors++;
        end
        assert (strobes == NUM_RESULTS)
        else flag_mismatch($sformatf("%0d emb_o strobes, expected %0d", strobes, NUM_RESULTS));
        next_cycle();
        assert (!done_o) else flag_mismatch("done_o wider than one cycle");
    endtask

    task automatic report_test(input int num, input string name, input int fails_before);
        if (total_failures() == fails_before) begin
            $display("Test %0d %s: passed", num, name);
        end else begin
            $display("Test %0d %s: failed, %0d errors", num, name,
                     total_failures() - fails_before);
            tests_failed++;
        end
    endtask

    initial begin
        int start_fails;
        int prev [`NUM_PATCHES][`EMB_DEPTH];
        param_t old_bias [`EMB_DEPTH];
        void'($urandom(32'h22c4_8071));
        errors = 0;
        tests_failed = 0;
        rst_n = 1'b0;
        eeg_valid_i = 1'b0;
        eeg_i = '0;
        start_i = 1'b0;
        param_wr_i = '0;
        repeat (4) @(posedge clk);
        #(DRIVE_DELAY);
        rst_n = 1'b1;

        start_fails = total_failures();
        repeat (10) begin
            next_cycle();
            assert (!emb_o.valid && !done_o && !busy_o)
            else flag_mismatch("output active while idle after reset");
        end
        report_test(1, "reset_idle", start_fails);

        start_fails = total_failures();
        for (int p = 0; p < `NUM_PATCHES; p++) begin
            for (int c = 0; c < `PATCH_LEN; c++) begin
                samples[p][c] = sample_t'($urandom);
            end
        end
        for (int r = 0; r < `EMB_DEPTH; r++) begin
            for (int c = 0; c < `PATCH_LEN; c++) begin
                weights[r][c] = param_t'($urandom);
            end
            biases[r] = param_t'($urandom);
        end
        for (int c = 0; c < `PATCH_LEN; c++) begin
            weights[1][c] = param_t'({1'b1, 7'($urandom)}); // Row 1 all negative
        end
        load_params();
        load_epoch();
        run_epoch(1'b0);
        report_test(2, "random_epoch", start_fails);

        start_fails = total_failures();
        run_epoch(1'b0);
        assert (first_strobe == `PATCH_LEN + 2)
        else flag_mismatch($sformatf("first strobe after %0d cycles", first_strobe));
        assert (done_at == last_strobe + 1)
        else flag_mismatch($sformatf("done_o %0d cycles after last strobe",
                                     done_at - last_strobe));
        report_test(3, "strobe_timing", start_fails);

        start_fails = total_failures();
        prev = observed;
        old_bias = biases;
        for (int r = 0; r < `EMB_DEPTH; r++) begin
            biases[r] = (r % 2 == 0) ? param_t'(127) : param_t'(-128);
            write_param(BIAS, r, 0, biases[r]);
        end
        run_epoch(1'b0);
        for (int p = 0; p < `NUM_PATCHES; p++) begin
            for (int r = 0; r < `EMB_DEPTH; r++) begin
                assert (observed[p][r] - prev[p][r] == int'(biases[r]) - int'(old_bias[r]))
                else flag_mismatch($sformatf("patch %0d row %0d moved by %0d", p, r,
                                             observed[p][r] - prev[p][r]));
            end
        end
        report_test(4, "extreme_bias", start_fails);

        start_fails = total_failures();
        prev = observed;
        run_epoch(1'b1);
        for (int p = 0; p < `NUM_PATCHES; p++) begin
            for (int r = 0; r < `EMB_DEPTH; r++) begin
                assert (observed[p][r] == prev[p][r])
                else flag_mismatch($sformatf("patch %0d row %0d changed by extra start", p, r));
            end
        end
        for (int p = 0; p < `NUM_PATCHES; p++) begin
            for (int c = 0; c < `PATCH_LEN; c++) begin
                samples[p][c] = sample_t'($urandom);
            end
        end
        load_epoch();
        run_epoch(1'b0);
        report_test(5, "restart_and_reload", start_fails);

        $display("Summary: 5 tests, %0d failed, %0d value errors, %0d assertion failures",
                 tests_failed, errors, cim_top_i.checker_i.fail_count);
        if (tests_failed == 0 && total_failures() == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
hw/cim_pkg.sv
hw/patch_sequencer.sv
hw/proj_lane.sv
hw/emb_collector.sv
hw/cim_top.sv
bench/cim_checker.sv
bench/cim_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module cim_tb -o cim_sim \
    && ./obj_dir/cim_sim +verilator+error+limit+1000 2>&1 | tee sim.log \
    || echo "Build or simulation did not complete"
grep -qx "Everything OK" sim.log && echo "Simulation passed" && exit 0 \
    || echo "Simulation failed" && exit 1
